//--- Makefile
VERILATOR ?= verilator
TOP       ?= memSystemTb
LOG       ?= sim.log
OBJDIR    ?= obj_dir
FILELIST  ?= sources.f

BIN := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJDIR)

run: compile
	./$(BIN) > $(LOG) 2>&1 || echo '*** FAILED ***' >> $(LOG)
	cat $(LOG)
	! grep -qF '*** FAILED ***' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- hw/cacheController.sv
module cacheController (
   input  logic                            clk,
   input  logic                            rstN,
   // cpu side
   input  logic                            reqValid,
   input  memPkg::cpuReqT                  req,
   output logic                            reqReady,
   output logic                            respValid,
   output memPkg::cpuRespT                 resp,
   // way status
   input  logic [memPkg::TagWidth-1:0]     way0Tag,
   input  logic                            way0Valid,
   input  logic                            way0Dirty,
   input  logic                            way0Hit,
   input  logic [memPkg::DataWidth-1:0]    way0Data,
   input  logic [memPkg::TagWidth-1:0]     way1Tag,
   input  logic                            way1Valid,
   input  logic                            way1Dirty,
   input  logic                            way1Hit,
   input  logic [memPkg::DataWidth-1:0]    way1Data,
   // way control, shared by both ways
   output logic [memPkg::IndexWidth-1:0]   wayIndex,
   output logic [memPkg::OffsetWidth-1:0]  wayOffset,
   output logic [memPkg::TagWidth-1:0]     wayTagIn,
   output logic [memPkg::DataWidth-1:0]    wayWrData,
   output logic                            markDirty,
   output logic                            wayWrite0,
   output logic                            wayWrite1,
   // memory side
   output logic                            memReqValid,
   output memPkg::memReqT                  memReq,
   input  logic                            memReqReady,
   input  logic                            memRespValid,
   input  logic [memPkg::DataWidth-1:0]    memRdData
);

   memPkg::ctrlStateT               state;
   memPkg::ctrlStateT               nextState;
   memPkg::cpuReqT                  reqReg;
   // way picked in compare and kept for the rest of the access
   logic                            selWay;
   logic                            hitReg;
   logic                            victim;
   logic [memPkg::LineCntWidth-1:0] issueCnt;
   logic [memPkg::LineCntWidth-1:0] returnCnt;

   logic                            anyHit;
   logic                            chooseWay;
   logic                            chosenValid;
   logic                            chosenDirty;
   logic [memPkg::TagWidth-1:0]     selTag;
   logic [memPkg::DataWidth-1:0]    selData;
   logic                            wayWriteEn;
   logic                            writeWay;
   logic                            memAccept;

   // ##############################
   // way choice
   // ##############################

   assign anyHit = way0Hit || way1Hit;

   // hitting way, then an empty way, then the victim
   always_comb begin
      if (way0Hit) chooseWay = 1'b0;
      else if (way1Hit) chooseWay = 1'b1;
      else if (!way0Valid) chooseWay = 1'b0;
      else if (!way1Valid) chooseWay = 1'b1;
      else chooseWay = victim;
   end

   assign chosenValid = chooseWay ? way1Valid : way0Valid;
   assign chosenDirty = chooseWay ? way1Dirty : way0Dirty;
   // old tag and line words of the kept way
   assign selTag      = selWay ? way1Tag : way0Tag;
   assign selData     = selWay ? way1Data : way0Data;
   assign memAccept   = memReqValid && memReqReady;

   // ##############################
   // next state and outputs
   // ##############################

   always_comb begin
      nextState   = state;
      reqReady    = 1'b0;
      respValid   = 1'b0;
      memReqValid = 1'b0;
      wayOffset   = reqReg.addr.fields.offset;
      wayWrData   = reqReg.wrData;
      markDirty   = 1'b1;
      wayWriteEn  = 1'b0;
      writeWay    = selWay;
      unique case (state)
         memPkg::stIdle: begin
            reqReady = 1'b1;
            if (reqValid) nextState = memPkg::stCompare;
         end
         memPkg::stCompare: begin
            // a write hit is stored here so a hit answers next cycle
            writeWay   = chooseWay;
            wayWriteEn = anyHit && reqReg.write;
            if (anyHit) nextState = memPkg::stRespond;
            else if (chosenValid && chosenDirty) nextState = memPkg::stEvict;
            else nextState = memPkg::stFill;
         end
         memPkg::stEvict: begin
            // read the old line word by word while it goes out
            memReqValid = 1'b1;
            wayOffset   = {issueCnt[memPkg::WordSelWidth-1:0], 1'b0};
            if (memAccept && (issueCnt == memPkg::LastWordCnt)) nextState = memPkg::stFill;
         end
         memPkg::stFill: begin
            memReqValid = (issueCnt != memPkg::FullLineCnt);
            // returning words go in clean, in return order
            wayOffset   = {returnCnt[memPkg::WordSelWidth-1:0], 1'b0};
            wayWrData   = memRdData;
            markDirty   = 1'b0;
            wayWriteEn  = memRespValid;
            if (memRespValid && (returnCnt == memPkg::LastWordCnt)) begin
               nextState = memPkg::stFinish;
            end
         end
         memPkg::stFinish: begin
            // pending cpu write lands on the fresh line
            wayWriteEn = reqReg.write;
            nextState  = memPkg::stRespond;
         end
         memPkg::stRespond: begin
            respValid = 1'b1;
            nextState = memPkg::stIdle;
         end
         default: nextState = memPkg::stIdle;
      endcase
   end

   assign wayIndex    = reqReg.addr.fields.index;
   assign wayTagIn    = reqReg.addr.fields.tag;
   assign wayWrite0   = wayWriteEn && !writeWay;
   assign wayWrite1   = wayWriteEn && writeWay;
   assign resp.rdData = selData;
   assign resp.hit    = hitReg;

   // eviction uses the old tag, fill the requested one
   always_comb begin
      memReq.addr.fields.tag    = (state == memPkg::stEvict) ? selTag : reqReg.addr.fields.tag;
      memReq.addr.fields.index  = reqReg.addr.fields.index;
      memReq.addr.fields.offset = {issueCnt[memPkg::WordSelWidth-1:0], 1'b0};
      memReq.wrData             = (state == memPkg::stEvict) ? selData : '0;
      memReq.write              = (state == memPkg::stEvict);
   end

   // ##############################
   // registers
   // ##############################

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state     <= memPkg::stIdle;
         victim    <= 1'b0;
         selWay    <= 1'b0;
         hitReg    <= 1'b0;
         issueCnt  <= '0;
         returnCnt <= '0;
      end else begin
         state <= nextState;
         if (state == memPkg::stCompare) begin
            selWay    <= chooseWay;
            hitReg    <= anyHit;
            issueCnt  <= '0;
            returnCnt <= '0;
         end else begin
            // eviction count restarts for the fill reads
            if (memAccept) begin
               issueCnt <= (nextState == memPkg::stFill && state == memPkg::stEvict)
                           ? '0 : issueCnt + 1'b1;
            end
            if (state == memPkg::stFill && memRespValid) returnCnt <= returnCnt + 1'b1;
         end
         // victim flips once per completed access
         if (state == memPkg::stRespond) victim <= !victim;
      end
   end

   // accepted request, held for the whole access
   always_ff @(posedge clk) begin
      if (reqValid && reqReady) reqReg <= req;
   end

endmodule

//--- hw/cacheWay.sv
module cacheWay (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic [memPkg::IndexWidth-1:0]   wayIndex,
   input  logic [memPkg::OffsetWidth-1:0]  wayOffset,
   input  logic [memPkg::TagWidth-1:0]     wayTagIn,
   input  logic [memPkg::DataWidth-1:0]    wayWrData,
   input  logic                            wayWrite,
   input  logic                            markDirty,
   output logic [memPkg::TagWidth-1:0]     tagOut,
   output logic                            validOut,
   output logic                            dirtyOut,
   output logic                            hitOut,
   output logic [memPkg::DataWidth-1:0]    rdData
);

   // ##############################
   // storage
   // ##############################

   // one tag per set
   logic [memPkg::TagWidth-1:0]  tagMem  [memPkg::NumSets];
   // line data kept as one flat word array
   logic [memPkg::DataWidth-1:0] dataMem [memPkg::NumSets * memPkg::WordsPerLine];
   // line state bits
   logic [memPkg::NumSets-1:0]   validBits;
   logic [memPkg::NumSets-1:0]   dirtyBits;

   // slot address seen through the union
   memPkg::memAddrU                   slotAddr;
   logic [memPkg::WordAddrWidth-1:0]  wordAddr;

   always_comb begin
      slotAddr.fields.tag    = wayTagIn;
      slotAddr.fields.index  = wayIndex;
      slotAddr.fields.offset = wayOffset;
   end

   // index and word select are adjacent, so the flat word address
   // is a slice of the raw word above the byte bit
   assign wordAddr = slotAddr.raw[memPkg::IndexWidth + memPkg::OffsetWidth - 1:1];

   // ##############################
   // lookup
   // ##############################

   assign tagOut   = tagMem[wayIndex];
   assign validOut = validBits[wayIndex];
   assign dirtyOut = dirtyBits[wayIndex];
   assign rdData   = dataMem[wordAddr];
   // hit needs the line present as well as a tag match
   assign hitOut   = validOut && (tagOut == wayTagIn);

   // ##############################
   // write
   // ##############################

   // line state, every line empty and clean after reset
   always_ff @(posedge clk) begin
      if (!rstN) begin
         validBits <= '0;
         dirtyBits <= '0;
      end else if (wayWrite) begin
         validBits[wayIndex] <= 1'b1;
         // fill words go in clean, cpu writes go in dirty
         dirtyBits[wayIndex] <= markDirty;
      end
   end

   // tag and word, no reset
   always_ff @(posedge clk) begin
      if (wayWrite) begin
         tagMem[wayIndex]  <= wayTagIn;
         dataMem[wordAddr] <= wayWrData;
      end
   end

endmodule

//--- hw/mainMemory.sv
module mainMemory (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          memReqValid,
   input  memPkg::memReqT                memReq,
   output logic                          memReqReady,
   output logic                          memRespValid,
   output logic [memPkg::DataWidth-1:0]  memRdData
);

   // ##############################
   // banks
   // ##############################

   // one bank per word of a line
   logic [memPkg::DataWidth-1:0]    bankMem [memPkg::WordsPerLine][memPkg::RowsPerBank];
   logic [memPkg::BusyCntWidth-1:0] busyCnt [memPkg::WordsPerLine];

   logic [memPkg::WordSelWidth-1:0] bankSel;
   logic [memPkg::RowWidth-1:0]     rowSel;
   logic                            accept;
   logic                            readAccept;

   // bank from the word select, row from tag and index
   assign bankSel = memReq.addr.fields.offset[memPkg::OffsetWidth-1:1];
   assign rowSel  = {memReq.addr.fields.tag, memReq.addr.fields.index};

   // stall while the addressed bank is still busy
   assign memReqReady = (busyCnt[bankSel] == '0);
   assign accept      = memReqValid && memReqReady;
   assign readAccept  = accept && !memReq.write;

   // busy counters, loaded on acceptance and counted down to zero
   always_ff @(posedge clk) begin
      for (int b = 0; b < memPkg::WordsPerLine; b++) begin
         if (!rstN) begin
            busyCnt[b] <= '0;
         end else if (accept && (int'(bankSel) == b)) begin
            busyCnt[b] <= memPkg::BusyLoad;
         end else if (busyCnt[b] != '0) begin
            busyCnt[b] <= busyCnt[b] - 1'b1;
         end
      end
   end

   // writes land at acceptance
   always_ff @(posedge clk) begin
      if (accept && memReq.write) begin
         bankMem[bankSel][rowSel] <= memReq.wrData;
      end
   end

   // ##############################
   // read pipeline
   // ##############################

   logic [memPkg::ReadLatency-1:0] pipeValid;
   logic [memPkg::DataWidth-1:0]   pipeData [memPkg::ReadLatency];

   // valid stages only, so several reads may be in flight
   always_ff @(posedge clk) begin
      if (!rstN) begin
         pipeValid <= '0;
      end else begin
         pipeValid <= {pipeValid[memPkg::ReadLatency-2:0], readAccept};
      end
   end

   // data stages shift every cycle
   always_ff @(posedge clk) begin
      pipeData[0] <= bankMem[bankSel][rowSel];
      for (int s = 1; s < memPkg::ReadLatency; s++) begin
         pipeData[s] <= pipeData[s-1];
      end
   end

   assign memRespValid = pipeValid[memPkg::ReadLatency-1];
   assign memRdData    = pipeData[memPkg::ReadLatency-1];

endmodule

//--- hw/memPkg.sv
package memPkg;

   // ##############################
   // widths and geometry
   // ##############################

   localparam int DataWidth    = 16;
   localparam int AddrWidth    = 16;
   localparam int TagWidth     = 5;
   localparam int IndexWidth   = 8;
   // byte offset inside a line of four 16-bit words
   localparam int OffsetWidth  = 3;
   localparam int WordsPerLine = 4;
   localparam int NumSets      = 256;

   // word select and bank number are the offset's upper bits
   localparam int WordSelWidth  = OffsetWidth - 1;
   localparam int WordAddrWidth = IndexWidth + WordSelWidth;
   // line counters need one extra bit to reach WordsPerLine
   localparam int LineCntWidth  = WordSelWidth + 1;
   localparam logic [LineCntWidth-1:0] LastWordCnt = LineCntWidth'(WordsPerLine - 1);
   localparam logic [LineCntWidth-1:0] FullLineCnt = LineCntWidth'(WordsPerLine);

   // ##############################
   // main memory timing
   // ##############################

   localparam int BankBusyCycles = 3;
   localparam int ReadLatency    = 2;
   localparam int BusyCntWidth   = $clog2(BankBusyCycles + 1);
   localparam logic [BusyCntWidth-1:0] BusyLoad = BusyCntWidth'(BankBusyCycles);
   // one bank row per tag and index pair
   localparam int RowWidth       = TagWidth + IndexWidth;
   localparam int RowsPerBank    = 2 ** RowWidth;

   // ##############################
   // address and transfer types
   // ##############################

   typedef struct packed {
      logic [TagWidth-1:0]    tag;
      logic [IndexWidth-1:0]  index;
      logic [OffsetWidth-1:0] offset;
   } addrFieldsT;

   // same address word, flat or split into tag, index and offset
   typedef union packed {
      logic [AddrWidth-1:0] raw;
      addrFieldsT           fields;
   } memAddrU;

   typedef struct packed {
      memAddrU              addr;
      logic [DataWidth-1:0] wrData;
      logic                 write;
   } cpuReqT;

   typedef struct packed {
      logic [DataWidth-1:0] rdData;
      logic                 hit;
   } cpuRespT;

   typedef struct packed {
      memAddrU              addr;
      logic [DataWidth-1:0] wrData;
      logic                 write;
   } memReqT;

   typedef enum logic [2:0] {
      stIdle, stCompare, stEvict, stFill, stFinish, stRespond
   } ctrlStateT;

endpackage

//--- hw/memSystem.sv
module memSystem (
   input  logic             clk,
   input  logic             rstN,
   input  logic             reqValid,
   input  memPkg::cpuReqT   req,
   output logic             reqReady,
   output logic             respValid,
   output memPkg::cpuRespT  resp
);

   // ##############################
   // way buses
   // ##############################

   logic [memPkg::IndexWidth-1:0]  wayIndex;
   logic [memPkg::OffsetWidth-1:0] wayOffset;
   logic [memPkg::TagWidth-1:0]    wayTagIn;
   logic [memPkg::DataWidth-1:0]   wayWrData;
   logic                           markDirty;
   logic                           wayWrite0;
   logic                           wayWrite1;

   // status back from each way
   logic [memPkg::TagWidth-1:0]    way0Tag;
   logic                           way0Valid;
   logic                           way0Dirty;
   logic                           way0Hit;
   logic [memPkg::DataWidth-1:0]   way0Data;
   logic [memPkg::TagWidth-1:0]    way1Tag;
   logic                           way1Valid;
   logic                           way1Dirty;
   logic                           way1Hit;
   logic [memPkg::DataWidth-1:0]   way1Data;

   // memory bus
   logic                           memReqValid;
   logic                           memReqReady;
   memPkg::memReqT                 memReq;
   logic                           memRespValid;
   logic [memPkg::DataWidth-1:0]   memRdData;

   cacheController ctrl (.*);

   // both ways see the same index, offset, tag and data
   cacheWay way0 (
      .clk, .rstN, .wayIndex, .wayOffset, .wayTagIn, .wayWrData, .markDirty,
      .wayWrite (wayWrite0), .tagOut (way0Tag), .validOut (way0Valid),
      .dirtyOut (way0Dirty), .hitOut (way0Hit), .rdData (way0Data)
   );

   cacheWay way1 (
      .clk, .rstN, .wayIndex, .wayOffset, .wayTagIn, .wayWrData, .markDirty,
      .wayWrite (wayWrite1), .tagOut (way1Tag), .validOut (way1Valid),
      .dirtyOut (way1Dirty), .hitOut (way1Hit), .rdData (way1Data)
   );

   mainMemory mem (.*);

endmodule

//--- sources.f
hw/memPkg.sv
hw/cacheWay.sv
hw/mainMemory.sv
hw/cacheController.sv
hw/memSystem.sv
testbench/tbClock.sv
testbench/memSystem_assertions.sv
testbench/memSystemTb.sv

//--- testbench/memSystemTb.sv
module memSystemTb;
   timeunit 1ns;
   timeprecision 100ps;

   // ##############################
   // run length
   // ##############################

   // directed accesses of all tests plus the random run
   localparam int DirectedAccesses = 21;
   localparam int RandomAccesses   = 300;
   localparam int CyclesPerAccess  = 200;
   localparam int ResetCycles      = 16;
   localparam int TimeoutCycles    =
      (DirectedAccesses + RandomAccesses) * CyclesPerAccess + ResetCycles;

   logic             clk;
   logic             rstN;
   logic             reqValid;
   logic             reqReady;
   logic             respValid;
   memPkg::cpuReqT   req;
   memPkg::cpuRespT  resp;
   int               errorCount;
   int               checkCount;

   // reference model of word memory keyed by word address plus per-way tags
   logic [memPkg::DataWidth-1:0] refMem [int];
   logic                         refValid [2][memPkg::NumSets];
   logic [memPkg::TagWidth-1:0]  refTag [2][memPkg::NumSets];
   logic                         refVictim;

   tbClock clkGen (.clk);

   memSystem dut (.clk, .rstN, .reqValid, .req, .reqReady, .respValid, .resp);

   // ##############################
   // helpers
   // ##############################

   // inputs change and outputs are read 1 ns after the edge
   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic reportError(input string what);
      errorCount++;
      $display("ERROR %0t %s", $time, what);
   endtask

   function automatic logic [15:0] makeAddr(input logic [memPkg::TagWidth-1:0] tag,
                                            input logic [memPkg::IndexWidth-1:0] index,
                                            input logic [1:0] word);
      memPkg::memAddrU a;
      a.fields.tag    = tag;
      a.fields.index  = index;
      // two bytes per word
      a.fields.offset = {word, 1'b0};
      return a.raw;
   endfunction

   // hitting way, else an empty way, else the victim
   // victim flips every access
   task automatic modelAccess(input logic [15:0] addr, input logic write,
                              input logic [15:0] data, output logic expHit,
                              output logic [15:0] expData);
      memPkg::memAddrU a;
      int              idx;
      logic            hit0;
      logic            hit1;
      logic            way;
      a.raw = addr;
      idx   = int'(a.fields.index);
      hit0  = refValid[0][idx] && (refTag[0][idx] == a.fields.tag);
      hit1  = refValid[1][idx] && (refTag[1][idx] == a.fields.tag);
      if (hit0) way = 1'b0;
      else if (hit1) way = 1'b1;
      else if (!refValid[0][idx]) way = 1'b0;
      else if (!refValid[1][idx]) way = 1'b1;
      else way = refVictim;
      expHit            = hit0 || hit1;
      refValid[way][idx] = 1'b1;
      refTag[way][idx]   = a.fields.tag;
      if (write) refMem[int'(addr[15:1])] = data;
      expData   = refMem.exists(int'(addr[15:1])) ? refMem[int'(addr[15:1])] : 'x;
      refVictim = !refVictim;
   endtask

   // one request through valid/ready, then wait for the response pulse
   task automatic doAccess(input logic [15:0] addr, input logic write, input logic [15:0] data,
                           output logic gotHit, output logic [15:0] gotData,
                           output int latency);
      logic        expHit;
      logic [15:0] expData;
      logic        wasReady;
      int          waitCnt;
      modelAccess(addr, write, data, expHit, expData);
      req.addr.raw = addr;
      req.wrData   = data;
      req.write    = write;
      reqValid     = 1'b1;
      wasReady     = 1'b0;
      waitCnt      = 0;
      // reqReady only moves at an edge, so its value now holds at the next one
      while (!wasReady && waitCnt < CyclesPerAccess) begin
         wasReady = reqReady;
         nextCycle();
         waitCnt++;
      end
      reqValid = 1'b0;
      // the accepting edge is behind us, so this is the first cycle after acceptance
      latency  = 1;
      gotHit   = 1'bx;
      gotData  = 'x;
      if (!wasReady) begin
         reportError("request was never accepted");
      end else begin
         while (!respValid && latency < CyclesPerAccess) begin
            nextCycle();
            latency++;
         end
         if (!respValid) begin
            reportError("no response to an accepted request");
         end else begin
            gotHit  = resp.hit;
            gotData = resp.rdData;
            checkEq("resp.hit", resp.hit, expHit);
            if (!write) checkEq("resp.rdData", resp.rdData, expData);
         end
      end
   endtask

   // ##############################
   // directed tests
   // ##############################

   task automatic testReset();
      checkEq("reqReady", reqReady, 1);
      checkEq("respValid", respValid, 0);
      checkEq("memReqValid", dut.memReqValid, 0);
   endtask

   task automatic testColdWrite();
      logic [15:0] addr;
      logic        hit;
      logic [15:0] rd;
      int          lat;
      addr = makeAddr(5'h01, 8'h10, 2'd0);
      doAccess(addr, 1'b1, 16'hA5C3, hit, rd, lat);
      checkEq("cold write hit", hit, 0);
      doAccess(addr, 1'b0, '0, hit, rd, lat);
      checkEq("reread hit", hit, 1);
      checkEq("reread data", rd, 16'hA5C3);
   endtask

   // tags 1 and 2 share index 0x20
   task automatic testTwoTags();
      logic        hit;
      logic [15:0] rd;
      int          lat;
      doAccess(makeAddr(5'h01, 8'h20, 2'd0), 1'b1, 16'h2A01, hit, rd, lat);
      doAccess(makeAddr(5'h02, 8'h20, 2'd0), 1'b1, 16'h2A02, hit, rd, lat);
      doAccess(makeAddr(5'h01, 8'h20, 2'd0), 1'b0, '0, hit, rd, lat);
      checkEq("tag 1 resident", hit, 1);
      doAccess(makeAddr(5'h02, 8'h20, 2'd0), 1'b0, '0, hit, rd, lat);
      checkEq("tag 2 resident", hit, 1);
   endtask

   task automatic testEviction();
      logic [memPkg::TagWidth-1:0] evictedTag;
      logic [15:0]                 oldData;
      logic                        hit;
      logic [15:0]                 rd;
      int                          lat;
      // both ways full, so the victim way goes
      evictedTag = refTag[refVictim][8'h20];
      oldData    = (evictedTag == 5'h01) ? 16'h2A01 : 16'h2A02;
      doAccess(makeAddr(5'h03, 8'h20, 2'd0), 1'b1, 16'h2A03, hit, rd, lat);
      checkEq("third tag hit", hit, 0);
      doAccess(makeAddr(evictedTag, 8'h20, 2'd0), 1'b0, '0, hit, rd, lat);
      checkEq("evicted hit", hit, 0);
      checkEq("evicted data", rd, oldData);
   endtask

   task automatic testRefill();
      logic        hit;
      logic [15:0] rd;
      int          lat;
      for (int w = 0; w < 4; w++) begin
         doAccess(makeAddr(5'h04, 8'h30, 2'(w)), 1'b1, 16'h3000 + 16'(w), hit, rd, lat);
      end
      // three new tags replace both ways at least once
      for (int t = 5; t < 8; t++) begin
         doAccess(makeAddr(5'(t), 8'h30, 2'd0), 1'b1, 16'h3100 + 16'(t), hit, rd, lat);
      end
      doAccess(makeAddr(5'h04, 8'h30, 2'd0), 1'b0, '0, hit, rd, lat);
      checkEq("refill miss", hit, 0);
      for (int w = 1; w < 4; w++) begin
         doAccess(makeAddr(5'h04, 8'h30, 2'(w)), 1'b0, '0, hit, rd, lat);
         checkEq("refill word hit", hit, 1);
         checkEq("refill word data", rd, 16'h3000 + 16'(w));
      end
   endtask

   task automatic testHitLatency();
      logic [15:0] addr;
      logic        hit;
      logic [15:0] rd;
      int          lat;
      addr = makeAddr(5'h08, 8'h50, 2'd2);
      doAccess(addr, 1'b1, 16'h5EED, hit, rd, lat);
      doAccess(addr, 1'b0, '0, hit, rd, lat);
      checkEq("latency hit", hit, 1);
      checkEq("hit latency", lat, 2);
   endtask

   // few indexes and tags with reads only of written addresses
   task automatic testRandom();
      logic [15:0] written [$];
      logic [15:0] addr;
      logic        hit;
      logic [15:0] rd;
      int          lat;
      for (int i = 0; i < RandomAccesses; i++) begin
         if (written.size() == 0 || ($urandom % 2) == 0) begin
            addr = makeAddr(5'($urandom % 4), 8'h40 + 8'($urandom % 3), 2'($urandom % 4));
            written.push_back(addr);
            doAccess(addr, 1'b1, 16'($urandom), hit, rd, lat);
         end else begin
            addr = written[$urandom % written.size()];
            doAccess(addr, 1'b0, '0, hit, rd, lat);
         end
      end
   endtask

   // ##############################
   // run and verdict
   // ##############################

   initial begin
      void'($urandom(32'h86090df4));
      errorCount = 0;
      checkCount = 0;
      rstN       = 1'b0;
      reqValid   = 1'b0;
      req        = '0;
      refVictim  = 1'b0;
      for (int s = 0; s < memPkg::NumSets; s++) begin
         refValid[0][s] = 1'b0;
         refValid[1][s] = 1'b0;
         refTag[0][s]   = '0;
         refTag[1][s]   = '0;
      end
      repeat (ResetCycles) @(posedge clk);
      #1;
      rstN = 1'b1;
      testReset();
      testColdWrite();
      testTwoTags();
      testEviction();
      testRefill();
      testHitLatency();
      testRandom();
      $display("checks %0d errors %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // watchdog
   initial begin
      repeat (TimeoutCycles) @(posedge clk);
      $display("ERROR timeout, the run did not end within %0d cycles", TimeoutCycles);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

//--- testbench/memSystem_assertions.sv
module memSystemAssertions (
   input logic               clk,
   input logic               rstN,
   input memPkg::ctrlStateT  state,
   input logic               reqReady,
   input logic               respValid,
   input logic               memReqValid,
   input logic               memReqReady,
   input memPkg::memReqT     memReq
);
   timeunit 1ns;
   timeprecision 100ps;

   // ##############################
   // protocol checks
   // ##############################

   // one response pulse per access
   respPulse: assert property (@(posedge clk) disable iff (!rstN)
      respValid |=> !respValid)
      else $error("respValid stayed high for two cycles");

   // a stalled memory request must not change
   memReqHold: assert property (@(posedge clk) disable iff (!rstN)
      (memReqValid && !memReqReady) |=> $stable(memReq))
      else $error("memReq changed while waiting for memReqReady");

   // requests are taken only in idle
   readyInIdle: assert property (@(posedge clk) disable iff (!rstN)
      reqReady |-> (state == memPkg::stIdle))
      else $error("reqReady high outside idle");

   // no stray response straight out of reset
   quietAfterReset: assert property (@(posedge clk)
      $rose(rstN) |-> !respValid)
      else $error("respValid high in the first cycle after reset");

endmodule

bind cacheController memSystemAssertions protocolChecks (.*);

//--- testbench/tbClock.sv
module tbClock (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   // half of the 8 ns period
   localparam realtime HalfPeriod = 4.0;

   initial clk = 1'b0;

   always #(HalfPeriod) clk = ~clk;

endmodule
